//--- src/mem_pkg.sv
package mem_pkg;

  // Word and byte geometry
  localparam int DATA_W      = 32;
  localparam int BYTE_W      = 8;
  localparam int BE_W        = DATA_W / BYTE_W;  // One enable per byte lane

  // Port side addressing
  localparam int ADDR_W      = 32;  // Byte address as seen by requesters
  localparam int WORD_OFFS   = 2;   // Byte offset bits inside one word

  // Memory depth in words
  localparam int MEM_WORDS   = 256;
  localparam int WORD_ADDR_W = $clog2(MEM_WORDS);

  // Operation carried by a request
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // Port waiting for the reply of the last accepted request
  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,  // Nothing in flight
    OWN_P0   = 2'd1,
    OWN_P1   = 2'd2
  } owner_e;

endpackage

//--- src/bus_pkg.sv
package bus_pkg;

  // One request, held stable beside req_i until granted
  typedef struct packed {
    mem_pkg::mem_op_e           op;
    logic [mem_pkg::ADDR_W-1:0] addr;   // Byte address, bits 1:0 ignored
    logic [mem_pkg::BE_W-1:0]   be;     // Only used by writes
    logic [mem_pkg::DATA_W-1:0] wdata;
  } mem_req_t;

  // One reply, qualified by rvalid_o one cycle after the grant
  typedef struct packed {
    logic [mem_pkg::DATA_W-1:0] rdata;  // Don't care for writes
    logic                       err;    // Word index beyond the memory
  } mem_rsp_t;

  // Reply lines of a port with nothing to return
  localparam mem_rsp_t RSP_ZERO = '{rdata: '0, err: 1'b0};

endpackage

//--- src/sp_ram.sv
`timescale 1ns/1ps

module sp_ram (
  input  logic                            clk,
  input  logic                            en_i,
  input  logic                            we_i,
  input  logic [mem_pkg::WORD_ADDR_W-1:0] addr_i,
  input  logic [mem_pkg::BE_W-1:0]        be_i,
  input  logic [mem_pkg::DATA_W-1:0]      wdata_i,
  output logic [mem_pkg::DATA_W-1:0]      rdata_o
);

  import mem_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];  // Undefined until written
  logic              wr_en;
  logic              rd_en;

  assign wr_en = en_i & we_i;
  assign rd_en = en_i & ~we_i;

  // Write only the enabled byte lanes
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // Full word read, valid the cycle after the enable
  // Holds its last value while idle or writing
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

//--- src/ram_mux.sv
`timescale 1ns/1ps

module ram_mux (
  input  logic                            clk,
  input  logic                            reset_i,
  // Port 0, loader and debug, highest priority
  input  logic                            p0_req_i,
  input  bus_pkg::mem_req_t               p0_req_data_i,
  output logic                            p0_gnt_o,
  output logic                            p0_rvalid_o,
  output bus_pkg::mem_rsp_t               p0_rsp_o,
  // Port 1, core data side
  input  logic                            p1_req_i,
  input  bus_pkg::mem_req_t               p1_req_data_i,
  output logic                            p1_gnt_o,
  output logic                            p1_rvalid_o,
  output bus_pkg::mem_rsp_t               p1_rsp_o,
  // Single port memory
  output logic                            ram_en_o,
  output logic                            ram_we_o,
  output logic [mem_pkg::WORD_ADDR_W-1:0] ram_addr_o,
  output logic [mem_pkg::BE_W-1:0]        ram_be_o,
  output logic [mem_pkg::DATA_W-1:0]      ram_wdata_o,
  input  logic [mem_pkg::DATA_W-1:0]      ram_rdata_i
);

  import mem_pkg::*;
  import bus_pkg::*;

  mem_req_t                    sel_req;   // Request of the granted port
  logic                        accept;
  logic [ADDR_W-WORD_OFFS-1:0] word_idx;  // Full index before range check
  logic                        in_range;
  owner_e                      owner_d;
  owner_e                      owner_q;
  logic                        err_q;
  mem_rsp_t                    rsp;

  // Fixed priority grant, port 1 waits while port 0 asks
  assign p0_gnt_o = p0_req_i;
  assign p1_gnt_o = p1_req_i & ~p0_req_i;
  assign accept   = p0_req_i | p1_req_i;

  always_comb begin
    if (p0_req_i) begin
      sel_req = p0_req_data_i;
      owner_d = OWN_P0;
    end else if (p1_req_i) begin
      sel_req = p1_req_data_i;
      owner_d = OWN_P1;
    end else begin
      sel_req = p1_req_data_i;  // Memory stays disabled
      owner_d = OWN_NONE;
    end
  end

  // Byte address to word index
  assign word_idx = sel_req.addr[ADDR_W-1:WORD_OFFS];

  // Any bit above the memory depth means out of range
  assign in_range = ~|word_idx[ADDR_W-WORD_OFFS-1:WORD_ADDR_W];

  // Memory only sees accepted, in range requests
  assign ram_en_o    = accept & in_range;
  assign ram_we_o    = ram_en_o & (sel_req.op == OP_WRITE);
  assign ram_addr_o  = word_idx[WORD_ADDR_W-1:0];
  assign ram_be_o    = sel_req.be;
  assign ram_wdata_o = sel_req.wdata;

  // Who gets the reply next cycle, and whether it failed
  always_ff @(posedge clk) begin
    if (reset_i) begin
      owner_q <= OWN_NONE;
      err_q   <= 1'b0;
    end else begin
      owner_q <= owner_d;
      err_q   <= accept & ~in_range;
    end
  end

  // Reply body, memory data or zero with err
  always_comb begin
    rsp = RSP_ZERO;
    if (err_q) begin
      rsp.err = 1'b1;
    end else begin
      rsp.rdata = ram_rdata_i;  // Registered inside sp_ram
    end
  end

  // Route the reply to its owner only
  always_comb begin
    p0_rvalid_o = 1'b0;
    p1_rvalid_o = 1'b0;
    p0_rsp_o    = RSP_ZERO;
    p1_rsp_o    = RSP_ZERO;
    case (owner_q)
      OWN_P0: begin
        p0_rvalid_o = 1'b1;
        p0_rsp_o    = rsp;
      end
      OWN_P1: begin
        p1_rvalid_o = 1'b1;
        p1_rsp_o    = rsp;
      end
      default: begin
        // Idle, both ports quiet
      end
    endcase
  end

endmodule

//--- src/data_mem_top.sv
`timescale 1ns/1ps

module data_mem_top (
  input  logic              clk,
  input  logic              reset_i,
  // Loader and debug port
  input  logic              p0_req_i,
  input  bus_pkg::mem_req_t p0_req_data_i,
  output logic              p0_gnt_o,
  output logic              p0_rvalid_o,
  output bus_pkg::mem_rsp_t p0_rsp_o,
  // Core data port
  input  logic              p1_req_i,
  input  bus_pkg::mem_req_t p1_req_data_i,
  output logic              p1_gnt_o,
  output logic              p1_rvalid_o,
  output bus_pkg::mem_rsp_t p1_rsp_o
);

  import mem_pkg::*;

  // Multiplexer to memory
  logic                   ram_en;
  logic                   ram_we;
  logic [WORD_ADDR_W-1:0] ram_addr;
  logic [BE_W-1:0]        ram_be;
  logic [DATA_W-1:0]      ram_wdata;
  logic [DATA_W-1:0]      ram_rdata;  // Back from the memory

  ram_mux mux0 (
    .clk           (clk),
    .reset_i       (reset_i),
    .p0_req_i      (p0_req_i),
    .p0_req_data_i (p0_req_data_i),
    .p0_gnt_o      (p0_gnt_o),
    .p0_rvalid_o   (p0_rvalid_o),
    .p0_rsp_o      (p0_rsp_o),
    .p1_req_i      (p1_req_i),
    .p1_req_data_i (p1_req_data_i),
    .p1_gnt_o      (p1_gnt_o),
    .p1_rvalid_o   (p1_rvalid_o),
    .p1_rsp_o      (p1_rsp_o),
    .ram_en_o      (ram_en),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_be_o      (ram_be),
    .ram_wdata_o   (ram_wdata),
    .ram_rdata_i   (ram_rdata)
  );

  sp_ram ram0 (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

//--- verif/data_mem_assert.sv
`timescale 1ns/1ps

module data_mem_assert (
  input logic                       clk,
  input logic                       reset_i,
  input logic                       p0_req_i,
  input logic [mem_pkg::ADDR_W-1:0] p0_addr_i,
  input logic                       p0_gnt_i,
  input logic                       p0_rvalid_i,
  input logic                       p1_req_i,
  input logic [mem_pkg::ADDR_W-1:0] p1_addr_i,
  input logic                       p1_gnt_i,
  input logic                       p1_rvalid_i,
  input logic                       ram_en_i
);

  import mem_pkg::*;

  logic [ADDR_W-1:0] sel_addr;
  logic              sel_in_range;

  // Address of the port that wins this cycle
  assign sel_addr     = p0_req_i ? p0_addr_i : p1_addr_i;
  assign sel_in_range = (sel_addr >> WORD_OFFS) < MEM_WORDS;

  a_p0_reply: assert property (@(posedge clk) disable iff (reset_i)
    (p0_req_i && p0_gnt_i) |=> p0_rvalid_i)
    else $error("Port 0 grant not followed by rvalid one cycle later");

  a_p1_reply: assert property (@(posedge clk) disable iff (reset_i)
    (p1_req_i && p1_gnt_i) |=> p1_rvalid_i)
    else $error("Port 1 grant not followed by rvalid one cycle later");

  // Replies go to one port at a time
  a_one_rvalid: assert property (@(posedge clk) !(p0_rvalid_i && p1_rvalid_i))
    else $error("Both rvalid outputs high in the same cycle");

  a_en_in_range: assert property (@(posedge clk) ram_en_i |-> sel_in_range)
    else $error("Memory enabled with an out of range word index");

  a_p0_first: assert property (@(posedge clk) p0_req_i |-> !p1_gnt_i)
    else $error("Port 1 granted while port 0 requests");

endmodule

bind ram_mux data_mem_assert mux_chk (
  .clk         (clk),
  .reset_i     (reset_i),
  .p0_req_i    (p0_req_i),
  .p0_addr_i   (p0_req_data_i.addr),
  .p0_gnt_i    (p0_gnt_o),
  .p0_rvalid_i (p0_rvalid_o),
  .p1_req_i    (p1_req_i),
  .p1_addr_i   (p1_req_data_i.addr),
  .p1_gnt_i    (p1_gnt_o),
  .p1_rvalid_i (p1_rvalid_o),
  .ram_en_i    (ram_en_o)
);

//--- verif/tb_data_mem.sv
`timescale 1ns/1ps

module tb_data_mem;

  import mem_pkg::*;
  import bus_pkg::*;

  localparam int RESET_CYC  = 3;
  localparam int N_TABLE    = 16;
  localparam int N_RAND     = 200;
  // Four cycles per item, the preload of every word, and reset
  localparam int MAX_CYCLES = (N_TABLE + N_RAND) * 4 + MEM_WORDS + 4 * RESET_CYC;

  // One row of the directed table
  typedef struct packed {
    logic              port;
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp_rdata;  // Compared for reads and errors
    logic              exp_err;
    logic              last;       // Drain all replies after this row
  } stim_t;

  // One queued request with its expected reply
  typedef struct packed {
    logic              port;
    mem_req_t          req;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_err;
    logic              from_model;  // Reply predicted at acceptance
  } item_t;

  localparam stim_t STIM_TBL [N_TABLE] = '{
    // Full word writes, then reads of the same words
    '{1'b0, OP_WRITE, 32'h0000_0010, 4'b1111, 32'h1122_3344, 32'h0000_0000, 1'b0, 1'b1},
    '{1'b0, OP_READ,  32'h0000_0010, 4'b1111, 32'h0000_0000, 32'h1122_3344, 1'b0, 1'b1},
    '{1'b1, OP_WRITE, 32'h0000_03fc, 4'b1111, 32'hdead_beef, 32'h0000_0000, 1'b0, 1'b1},
    '{1'b1, OP_READ,  32'h0000_03fc, 4'b0000, 32'h0000_0000, 32'hdead_beef, 1'b0, 1'b1},
    // Lanes 0 and 2 only
    '{1'b1, OP_WRITE, 32'h0000_0010, 4'b0101, 32'haabb_ccdd, 32'h0000_0000, 1'b0, 1'b1},
    '{1'b0, OP_READ,  32'h0000_0010, 4'b1111, 32'h0000_0000, 32'h11bb_33dd, 1'b0, 1'b1},
    // Low address bits, then past the end (0x410 would alias word 4)
    '{1'b1, OP_READ,  32'h0000_0013, 4'b1111, 32'h0000_0000, 32'h11bb_33dd, 1'b0, 1'b1},
    '{1'b0, OP_WRITE, 32'h0000_0410, 4'b1111, 32'hcafe_f00d, 32'h0000_0000, 1'b1, 1'b1},
    '{1'b1, OP_READ,  32'h8000_0010, 4'b1111, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b1},
    '{1'b0, OP_READ,  32'h0000_0011, 4'b1111, 32'h0000_0000, 32'h11bb_33dd, 1'b0, 1'b1},
    // Both ports in the same cycle
    '{1'b0, OP_WRITE, 32'h0000_0020, 4'b1111, 32'h0bad_f00d, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, OP_READ,  32'h0000_0020, 4'b1111, 32'h0000_0000, 32'h0bad_f00d, 1'b0, 1'b1},
    // Back to back on port 1
    '{1'b1, OP_WRITE, 32'h0000_0024, 4'b1111, 32'h1234_5678, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, OP_READ,  32'h0000_0024, 4'b1111, 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0},
    '{1'b1, OP_WRITE, 32'h0000_0024, 4'b1000, 32'hff00_0000, 32'h0000_0000, 1'b0, 1'b0},
    '{1'b1, OP_READ,  32'h0000_0027, 4'b1111, 32'h0000_0000, 32'hff34_5678, 1'b0, 1'b1}
  };

  logic     clk;
  logic     reset_i;
  logic     p0_req_i;
  mem_req_t p0_req_data_i;
  logic     p0_gnt_o;
  logic     p0_rvalid_o;
  mem_rsp_t p0_rsp_o;
  logic     p1_req_i;
  mem_req_t p1_req_data_i;
  logic     p1_gnt_o;
  logic     p1_rvalid_o;
  mem_rsp_t p1_rsp_o;

  logic [DATA_W-1:0] model_mem [MEM_WORDS];  // Mirror of the memory
  item_t             p0_q [$];
  item_t             p1_q [$];
  item_t             pend;      // Accepted last cycle, reply due now
  logic              pend_vld;
  int                check_cnt = 0;
  int                err_cnt   = 0;
  int                cycle_cnt = 0;
  logic [31:0]       rng_state = 32'hc438_bddc;

  data_mem_top dut0 (
    .clk           (clk),
    .reset_i       (reset_i),
    .p0_req_i      (p0_req_i),
    .p0_req_data_i (p0_req_data_i),
    .p0_gnt_o      (p0_gnt_o),
    .p0_rvalid_o   (p0_rvalid_o),
    .p0_rsp_o      (p0_rsp_o),
    .p1_req_i      (p1_req_i),
    .p1_req_data_i (p1_req_data_i),
    .p1_gnt_o      (p1_gnt_o),
    .p1_rvalid_o   (p1_rvalid_o),
    .p1_rsp_o      (p1_rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog
  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Preload pattern, every address bit matters
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
  endfunction

  // Reference model of one accepted request
  function automatic void model_step(input mem_req_t r, output logic [DATA_W-1:0] rdata,
                                     output logic err);
    logic [ADDR_W-1:0] idx;
    idx   = r.addr >> 2;
    rdata = '0;
    err   = (idx >= MEM_WORDS);
    if (!err) begin
      if (r.op == OP_WRITE) begin
        for (int b = 0; b < BE_W; b++) begin
          if (r.be[b]) begin
            model_mem[idx[WORD_ADDR_W-1:0]][8*b +: 8] = r.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata = model_mem[idx[WORD_ADDR_W-1:0]];  // be ignored on reads
      end
    end
  endfunction

  function automatic item_t row_item(input stim_t row);
    item_t it;
    it.port       = row.port;
    it.req.op     = row.op;
    it.req.addr   = row.addr;
    it.req.be     = row.be;
    it.req.wdata  = row.wdata;
    it.exp_rdata  = row.exp_rdata;
    it.exp_err    = row.exp_err;
    it.from_model = 1'b0;
    return it;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    assert (act === exp)
      else begin
        err_cnt++;
        $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    check_cnt++;
    assert (act === exp)
      else begin
        err_cnt++;
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
  endtask

  // Nothing due on either port
  task automatic check_quiet();
    check_bit("p0_rvalid_o", 1'b0, p0_rvalid_o);
    check_bit("p1_rvalid_o", 1'b0, p1_rvalid_o);
    check_word("p0_rsp_o.rdata", '0, p0_rsp_o.rdata);
    check_word("p1_rsp_o.rdata", '0, p1_rsp_o.rdata);
    check_bit("p0_rsp_o.err", 1'b0, p0_rsp_o.err);
    check_bit("p1_rsp_o.err", 1'b0, p1_rsp_o.err);
  endtask

  task automatic check_reply();
    string    own;
    logic     own_vld;
    logic     oth_vld;
    mem_rsp_t own_rsp;
    if (!pend_vld) begin
      check_quiet();
    end else begin
      own     = pend.port ? "p1" : "p0";
      own_vld = pend.port ? p1_rvalid_o : p0_rvalid_o;
      oth_vld = pend.port ? p0_rvalid_o : p1_rvalid_o;
      own_rsp = pend.port ? p1_rsp_o : p0_rsp_o;
      check_bit({own, "_rvalid_o"}, 1'b1, own_vld);
      check_bit(pend.port ? "p0_rvalid_o" : "p1_rvalid_o", 1'b0, oth_vld);
      check_bit({own, "_rsp_o.err"}, pend.exp_err, own_rsp.err);
      if (pend.req.op == OP_READ || pend.exp_err) begin
        check_word({own, "_rsp_o.rdata"}, pend.exp_rdata, own_rsp.rdata);
      end
    end
  endtask

  task automatic enqueue(input item_t it);
    if (it.port) begin
      p1_q.push_back(it);
    end else begin
      p0_q.push_back(it);
    end
  endtask

  // One clock: drive queue heads, check the due reply and the grants
  task automatic step_cycle();
    item_t             acc;
    logic              acc_vld;
    logic [DATA_W-1:0] m_rdata;
    logic              m_err;
    @(posedge clk);
    #1;
    p0_req_i      = (p0_q.size() > 0);
    p0_req_data_i = '0;
    if (p0_req_i) begin
      p0_req_data_i = p0_q[0].req;
    end
    p1_req_i      = (p1_q.size() > 0);
    p1_req_data_i = '0;
    if (p1_req_i) begin
      p1_req_data_i = p1_q[0].req;
    end
    @(negedge clk);
    check_reply();
    check_bit("p0_gnt_o", p0_req_i, p0_gnt_o);
    check_bit("p1_gnt_o", p1_req_i & ~p0_req_i, p1_gnt_o);
    acc     = '0;
    acc_vld = 1'b0;
    if (p0_req_i && p0_gnt_o) begin
      acc     = p0_q.pop_front();
      acc_vld = 1'b1;
    end else if (p1_req_i && p1_gnt_o) begin
      acc     = p1_q.pop_front();
      acc_vld = 1'b1;
    end
    if (acc_vld) begin
      model_step(acc.req, m_rdata, m_err);
      if (acc.from_model) begin
        acc.exp_rdata = m_rdata;
        acc.exp_err   = m_err;
      end
    end
    pend     = acc;
    pend_vld = acc_vld;
  endtask

  task automatic drain();
    do begin
      step_cycle();
    end while (p0_q.size() > 0 || p1_q.size() > 0 || pend_vld);
  endtask

  initial begin
    item_t       it;
    logic [31:0] r;
    logic [31:0] d;
    $timeformat(-9, 0, " ns", 0);
    reset_i       = 1'b1;
    p0_req_i      = 1'b0;
    p0_req_data_i = '0;
    p1_req_i      = 1'b0;
    p1_req_data_i = '0;
    pend          = '0;
    pend_vld      = 1'b0;

    // Both ports quiet during reset and right after it
    repeat (RESET_CYC) begin
      @(posedge clk);
      #1;
      check_quiet();
    end
    reset_i = 1'b0;
    @(negedge clk);
    check_quiet();

    // Every word written once through the loader port
    for (int w = 0; w < MEM_WORDS; w++) begin
      it            = '0;
      it.req.op     = OP_WRITE;
      it.req.addr   = w << 2;
      it.req.be     = '1;
      it.req.wdata  = fill_word(it.req.addr);
      it.from_model = 1'b1;
      enqueue(it);
    end
    drain();

    for (int i = 0; i < N_TABLE; i++) begin
      enqueue(row_item(STIM_TBL[i]));
      if (STIM_TBL[i].last) begin
        drain();
      end
    end

    // Mixed traffic, sometimes several items queued at once
    for (int n = 0; n < N_RAND; n++) begin
      r            = next_rand();
      d            = next_rand();
      it           = '0;
      it.port      = r[0];
      it.req.op    = mem_op_e'(r[1]);
      it.req.be    = r[7:4];
      it.req.wdata = d;
      if (r[11:8] == 4'h0) begin
        it.req.addr = d | 32'h0000_0400;  // Beyond the memory
      end else begin
        it.req.addr = {22'h0, r[21:12]};
      end
      it.from_model = 1'b1;
      enqueue(it);
      if (r[3:2] != 2'b00 || n == N_RAND - 1) begin
        drain();
      end
    end

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
src/mem_pkg.sv
src/bus_pkg.sv
src/sp_ram.sv
src/ram_mux.sv
src/data_mem_top.sv
verif/data_mem_assert.sv
verif/tb_data_mem.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_data_mem
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	elif ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation stopped without a status line, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
